//--- verilog/exe_pkg.sv
package exe_pkg;

	// privilege levels, 2 is reserved
	typedef enum logic [1:0] {
		PRIV_U = 2'd0,
		PRIV_S = 2'd1,
		PRIV_M = 2'd3
	} priv_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_GE,
		BR_LTU,
		BR_GEU
	} br_cond_e;

	typedef enum logic [2:0] {
		WB_ALU,
		WB_PC4,
		WB_UIMM,
		WB_AUIPC,
		WB_CSR
	} wb_sel_e;

	typedef enum logic [1:0] {
		CSR_NONE,
		CSR_WRITE,
		CSR_SET,
		CSR_CLEAR
	} csr_op_e;

	typedef enum logic [1:0] {
		RET_NONE,
		RET_M,
		RET_S,
		RET_U
	} ret_e;

	typedef struct packed {
		logic instr_misaligned;
		logic ecall;
		logic ebreak;
		logic illegal_instr;
		ret_e ret;
	} exc_flags_s;

	typedef struct packed {
		logic [31:0] op_a;
		logic [31:0] op_b;
		alu_op_e     alu_op;
		br_cond_e    br_cond;
		logic        jal;
		logic        jalr;
		logic [31:0] b_imm;
		logic [31:0] j_imm;
		logic [31:0] u_imm;
		logic [31:0] pc;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic        we;
		wb_sel_e     wb_sel;
		csr_op_e     csr_op;
		logic        csr_use_imm;
		// zimm field of csrrwi/csrrsi/csrrci
		logic [4:0]  csr_imm;
		logic [11:0] csr_addr;
		logic [31:0] csr_data;
		exc_flags_s  exc;
	} issue_s;

	typedef struct packed {
		logic m_timer;
		logic s_timer;
		logic u_timer;
		logic ext;
		logic m_tie;
		logic s_tie;
		logic u_tie;
		logic m_eie;
		logic s_eie;
		logic u_eie;
	} irq_s;

	typedef struct packed {
		logic        interrupt;
		logic [30:0] code;
	} cause_s;

	// synchronous codes
	localparam logic [30:0] I_ADDR_MISALIGNED = 31'd0;
	localparam logic [30:0] I_ILLEGAL         = 31'd2;
	localparam logic [30:0] BREAKPOINT        = 31'd3;
	localparam logic [30:0] U_CALL            = 31'd8;
	localparam logic [30:0] S_CALL            = 31'd9;
	localparam logic [30:0] M_CALL            = 31'd11;

	// interrupt codes
	localparam logic [30:0] U_INT_TIMER = 31'd4;
	localparam logic [30:0] S_INT_TIMER = 31'd5;
	localparam logic [30:0] M_INT_TIMER = 31'd7;
	localparam logic [30:0] U_INT_EXT   = 31'd8;
	localparam logic [30:0] S_INT_EXT   = 31'd9;
	localparam logic [30:0] M_INT_EXT   = 31'd11;

	typedef struct packed {
		logic [31:0] data;
		logic [4:0]  rd;
		logic        we;
	} wb_s;

	typedef struct packed {
		logic [31:0] data;
		logic [11:0] addr;
		logic        we;
	} csr_wb_s;

	typedef struct packed {
		logic        taken;
		logic [31:0] target;
	} redirect_s;

	typedef struct packed {
		logic   exception;
		cause_s cause;
		ret_e   ret;
		logic   m_int;
		logic   s_int;
		logic   u_int;
	} trap_s;

	// set/clear with a zero source only reads the CSR
	function automatic logic csr_write_intent(input issue_s ins);
		logic src_nonzero;
		src_nonzero = ins.csr_use_imm ? (ins.csr_imm != 5'd0) : (ins.rs1 != 5'd0);
		return (ins.csr_op == CSR_WRITE) ||
			((ins.csr_op inside {CSR_SET, CSR_CLEAR}) && src_nonzero);
	endfunction

endpackage

//--- verilog/exe_issue_reg.sv
`timescale 1ns/1ps

module exe_issue_reg (
	input  logic            clk,
	input  logic            nrst,
	input  logic            flush,
	input  exe_pkg::issue_s issue,
	output exe_pkg::issue_s stage5
);

	// stage 5 holds the issued instruction for one cycle
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			stage5 <= '0;
		end
		else if (flush)
		begin
			// turn the slot into a bubble
			stage5 <= '0;
		end
		else
		begin
			stage5 <= issue;
		end
	end

	flush_leaves_bubble: assert property (
		@(posedge clk) disable iff (!nrst)
		flush |=> (!stage5.we && stage5.csr_op == exe_pkg::CSR_NONE)
	)
	else $error("stage5 still live after flush");

endmodule

//--- verilog/exe_alu.sv
`timescale 1ns/1ps

module exe_alu (
	input  exe_pkg::issue_s   stage5,
	output logic [31:0]       result,
	output exe_pkg::redirect_s redirect
);

	logic [4:0]  shamt;
	logic        eq;
	logic        lt_s;
	logic        lt_u;
	logic        cond_true;
	logic [31:0] br_target;
	logic [31:0] jal_target;
	logic [31:0] jalr_sum;

	assign shamt = stage5.op_b[4:0];
	assign eq    = stage5.op_a == stage5.op_b;
	assign lt_s  = $signed(stage5.op_a) < $signed(stage5.op_b);
	assign lt_u  = stage5.op_a < stage5.op_b;

	always_comb
	begin
		unique case (stage5.alu_op)
			exe_pkg::ALU_ADD:  result = stage5.op_a + stage5.op_b;
			exe_pkg::ALU_SUB:  result = stage5.op_a - stage5.op_b;
			exe_pkg::ALU_SLL:  result = stage5.op_a << shamt;
			exe_pkg::ALU_SLT:  result = {31'd0, lt_s};
			exe_pkg::ALU_SLTU: result = {31'd0, lt_u};
			exe_pkg::ALU_XOR:  result = stage5.op_a ^ stage5.op_b;
			exe_pkg::ALU_SRL:  result = stage5.op_a >> shamt;
			exe_pkg::ALU_SRA:  result = $unsigned($signed(stage5.op_a) >>> shamt);
			exe_pkg::ALU_OR:   result = stage5.op_a | stage5.op_b;
			exe_pkg::ALU_AND:  result = stage5.op_a & stage5.op_b;
			default:           result = 32'd0;
		endcase
	end

	// branch condition on the same operands
	always_comb
	begin
		unique case (stage5.br_cond)
			exe_pkg::BR_EQ:  cond_true = eq;
			exe_pkg::BR_NE:  cond_true = !eq;
			exe_pkg::BR_LT:  cond_true = lt_s;
			exe_pkg::BR_GE:  cond_true = !lt_s;
			exe_pkg::BR_LTU: cond_true = lt_u;
			exe_pkg::BR_GEU: cond_true = !lt_u;
			default:         cond_true = 1'b0;
		endcase
	end

	assign br_target  = stage5.pc + stage5.b_imm;
	assign jal_target = stage5.pc + stage5.j_imm;
	// op_b carries the I immediate for jalr
	assign jalr_sum   = stage5.op_a + stage5.op_b;

	assign redirect = '{
		taken:  cond_true || stage5.jal || stage5.jalr,
		target: stage5.jalr ? {jalr_sum[31:1], 1'b0} :
			stage5.jal ? jal_target : br_target
	};

endmodule

//--- verilog/csr_update.sv
`timescale 1ns/1ps

module csr_update (
	input  exe_pkg::issue_s stage5,
	input  exe_pkg::priv_e  current_mode,
	output logic [31:0]     csr_new,
	output logic [31:0]     csr_old,
	output logic            illegal
);

	logic [31:0] src;
	logic        write_intent;
	logic        priv_low;
	logic        read_only;

	// zimm is zero extended
	assign src     = stage5.csr_use_imm ? {27'd0, stage5.csr_imm} : stage5.op_a;
	assign csr_old = stage5.csr_data;

	always_comb
	begin
		unique case (stage5.csr_op)
			exe_pkg::CSR_WRITE: csr_new = src;
			exe_pkg::CSR_SET:   csr_new = csr_old | src;
			exe_pkg::CSR_CLEAR: csr_new = csr_old & ~src;
			default:            csr_new = csr_old;
		endcase
	end

	assign write_intent = exe_pkg::csr_write_intent(stage5);

	// addr[9:8] is the lowest privilege allowed to touch the CSR
	assign priv_low  = stage5.csr_addr[9:8] > 2'(current_mode);
	// addr[11:10] == 2'b11 marks read-only space
	assign read_only = (stage5.csr_addr[11:10] == 2'b11) && write_intent;

	assign illegal = (stage5.csr_op != exe_pkg::CSR_NONE) && (priv_low || read_only);

endmodule

//--- verilog/trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl (
	input  exe_pkg::exc_flags_s flags6,
	input  logic                csr_illegal6,
	input  exe_pkg::irq_s       irq,
	input  exe_pkg::priv_e      current_mode,
	output exe_pkg::trap_s      trap
);

	logic not_m;
	logic in_u;
	logic m_ext;
	logic s_ext;
	logic u_ext;
	logic m_tmr;
	logic s_tmr;
	logic u_tmr;
	logic any_sync;

	assign not_m = current_mode != exe_pkg::PRIV_M;
	assign in_u  = current_mode == exe_pkg::PRIV_U;

	// machine interrupts are masked only by their enables
	assign m_ext = irq.m_eie && irq.ext;
	assign m_tmr = irq.m_tie && irq.m_timer;
	assign s_ext = not_m && irq.s_eie && irq.ext;
	assign s_tmr = not_m && irq.s_tie && irq.s_timer;
	assign u_ext = in_u && irq.u_eie && irq.ext;
	assign u_tmr = in_u && irq.u_tie && irq.u_timer;

	assign any_sync = flags6.instr_misaligned || flags6.ecall || flags6.ebreak ||
		flags6.illegal_instr || csr_illegal6 || (flags6.ret != exe_pkg::RET_NONE);

	always_comb
	begin
		trap           = '0;
		trap.m_int     = m_ext || m_tmr;
		trap.s_int     = s_ext || s_tmr;
		trap.u_int     = u_ext || u_tmr;
		trap.ret       = flags6.ret;
		trap.exception = trap.m_int || trap.s_int || trap.u_int || any_sync;

		// interrupts first, then synchronous causes
		trap.cause.interrupt = trap.m_int || trap.s_int || trap.u_int;
		if (m_ext)
			trap.cause.code = exe_pkg::M_INT_EXT;
		else if (s_ext)
			trap.cause.code = exe_pkg::S_INT_EXT;
		else if (m_tmr)
			trap.cause.code = exe_pkg::M_INT_TIMER;
		else if (s_tmr)
			trap.cause.code = exe_pkg::S_INT_TIMER;
		else if (u_ext)
			trap.cause.code = exe_pkg::U_INT_EXT;
		else if (u_tmr)
			trap.cause.code = exe_pkg::U_INT_TIMER;
		else if (flags6.instr_misaligned)
			trap.cause.code = exe_pkg::I_ADDR_MISALIGNED;
		else if (flags6.illegal_instr || csr_illegal6)
			trap.cause.code = exe_pkg::I_ILLEGAL;
		else if (flags6.ecall)
		begin
			// ecall code depends on the mode it came from
			unique case (current_mode)
				exe_pkg::PRIV_U: trap.cause.code = exe_pkg::U_CALL;
				exe_pkg::PRIV_S: trap.cause.code = exe_pkg::S_CALL;
				default:         trap.cause.code = exe_pkg::M_CALL;
			endcase
		end
		else if (flags6.ebreak)
			trap.cause.code = exe_pkg::BREAKPOINT;
	end

endmodule

//--- verilog/exe_commit_reg.sv
`timescale 1ns/1ps

module exe_commit_reg (
	input  logic                clk,
	input  logic                nrst,
	input  logic                flush,
	input  exe_pkg::issue_s     stage5,
	input  logic [31:0]         alu_result,
	input  logic [31:0]         csr_new,
	input  logic [31:0]         csr_old,
	input  logic                csr_illegal,
	output exe_pkg::wb_s        wb,
	output exe_pkg::csr_wb_s    csr_wb,
	output exe_pkg::exc_flags_s flags6,
	output logic                csr_illegal6,
	output logic [31:0]         pc6
);

	logic            we6;
	logic [4:0]      rd6;
	exe_pkg::wb_sel_e wb_sel6;
	logic            csr_we6;
	logic [31:0]     alu6;
	logic [31:0]     csr_new6;
	logic [31:0]     csr_old6;
	logic [31:0]     u_imm6;
	logic [31:0]     auipc6;
	logic [11:0]     csr_addr6;

	// control state
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			we6          <= 1'b0;
			rd6          <= 5'd0;
			wb_sel6      <= exe_pkg::WB_ALU;
			csr_we6      <= 1'b0;
			flags6       <= '0;
			csr_illegal6 <= 1'b0;
			pc6          <= 32'd0;
		end
		else if (flush)
		begin
			// pc6 keeps the trapping pc
			we6          <= 1'b0;
			rd6          <= 5'd0;
			wb_sel6      <= exe_pkg::WB_ALU;
			csr_we6      <= 1'b0;
			flags6       <= '0;
			csr_illegal6 <= 1'b0;
		end
		else
		begin
			we6          <= stage5.we;
			rd6          <= stage5.rd;
			wb_sel6      <= stage5.wb_sel;
			csr_we6      <= (stage5.csr_op != exe_pkg::CSR_NONE) &&
				exe_pkg::csr_write_intent(stage5) && !csr_illegal;
			flags6       <= stage5.exc;
			csr_illegal6 <= csr_illegal;
			pc6          <= stage5.pc;
		end
	end

	// data path
	always_ff @(posedge clk)
	begin
		if (flush)
		begin
			alu6      <= 32'd0;
			csr_new6  <= 32'd0;
			csr_old6  <= 32'd0;
			u_imm6    <= 32'd0;
			auipc6    <= 32'd0;
			csr_addr6 <= 12'd0;
		end
		else
		begin
			alu6      <= alu_result;
			csr_new6  <= csr_new;
			csr_old6  <= csr_old;
			u_imm6    <= stage5.u_imm;
			auipc6    <= stage5.pc + stage5.u_imm;
			csr_addr6 <= stage5.csr_addr;
		end
	end

	always_comb
	begin
		wb.rd = rd6;
		// x0 is never written
		wb.we = we6 && (rd6 != 5'd0);
		unique case (wb_sel6)
			exe_pkg::WB_PC4:   wb.data = pc6 + 32'd4;
			exe_pkg::WB_UIMM:  wb.data = u_imm6;
			exe_pkg::WB_AUIPC: wb.data = auipc6;
			exe_pkg::WB_CSR:   wb.data = csr_old6;
			default:           wb.data = alu6;
		endcase
	end

	assign csr_wb = '{data: csr_new6, addr: csr_addr6, we: csr_we6};

	flush_blocks_writes: assert property (
		@(posedge clk) disable iff (!nrst)
		flush |=> (!wb.we && !csr_wb.we)
	)
	else $error("write-back live after flush");

endmodule

//--- verilog/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
	input  logic               clk,
	input  logic               nrst,
	input  exe_pkg::issue_s    issue,
	input  exe_pkg::irq_s      irq,
	input  exe_pkg::priv_e     current_mode,
	output exe_pkg::wb_s       wb,
	output exe_pkg::csr_wb_s   csr_wb,
	output exe_pkg::redirect_s redirect,
	output exe_pkg::trap_s     trap,
	output logic [31:0]        pc6
);

	exe_pkg::issue_s     stage5;
	logic [31:0]         alu_result;
	logic [31:0]         csr_new;
	logic [31:0]         csr_old;
	logic                csr_illegal;
	exe_pkg::exc_flags_s flags6;
	logic                csr_illegal6;

	// stage 5
	exe_issue_reg u_issue_reg (
		.clk    (clk),
		.nrst   (nrst),
		.flush  (trap.exception),
		.issue  (issue),
		.stage5 (stage5)
	);

	exe_alu u_alu (
		.stage5   (stage5),
		.result   (alu_result),
		.redirect (redirect)
	);

	csr_update u_csr_update (
		.stage5       (stage5),
		.current_mode (current_mode),
		.csr_new      (csr_new),
		.csr_old      (csr_old),
		.illegal      (csr_illegal)
	);

	// stage 6
	exe_commit_reg u_commit_reg (
		.clk          (clk),
		.nrst         (nrst),
		.flush        (trap.exception),
		.stage5       (stage5),
		.alu_result   (alu_result),
		.csr_new      (csr_new),
		.csr_old      (csr_old),
		.csr_illegal  (csr_illegal),
		.wb           (wb),
		.csr_wb       (csr_wb),
		.flags6       (flags6),
		.csr_illegal6 (csr_illegal6),
		.pc6          (pc6)
	);

	// exception from here flushes both stages
	trap_ctrl u_trap_ctrl (
		.flags6       (flags6),
		.csr_illegal6 (csr_illegal6),
		.irq          (irq),
		.current_mode (current_mode),
		.trap         (trap)
	);

endmodule

//--- dv/exe_tb.sv
`timescale 1ns/1ps

module exe_tb;

	localparam int    PERIOD       = 40;
	localparam int    RESET_CYCLES = 8;
	// iterations after the last line so offset 2 checks still run
	localparam int    DRAIN        = 3;
	localparam string VEC_FILE     = "dv/exe_vectors.txt";

	// expected response of one vector line, offset f means no check
	typedef struct packed {
		logic [3:0]  wb_off;
		logic [3:0]  red_off;
		logic [3:0]  trap_off;
		logic        wb_we;
		logic [31:0] wb_data;
		logic        cwb_we;
		logic [31:0] cwb_data;
		logic        taken;
		logic [31:0] target;
		logic        exc;
		logic [31:0] cause;
	} expect_s;

	logic               clk;
	logic               nrst;
	exe_pkg::issue_s    issue;
	exe_pkg::irq_s      irq;
	exe_pkg::priv_e     current_mode;
	exe_pkg::wb_s       wb;
	exe_pkg::csr_wb_s   csr_wb;
	exe_pkg::redirect_s redirect;
	exe_pkg::trap_s     trap;
	logic [31:0]        pc6;

	exe_pkg::issue_s vec_issue [$];
	exe_pkg::irq_s   vec_irq [$];
	exe_pkg::priv_e  vec_mode [$];
	expect_s         vec_exp [$];
	int              vec_src [$];
	int              n_lines;
	logic            loaded;

	exe_stage UUT (
		.clk          (clk),
		.nrst         (nrst),
		.issue        (issue),
		.irq          (irq),
		.current_mode (current_mode),
		.wb           (wb),
		.csr_wb       (csr_wb),
		.redirect     (redirect),
		.trap         (trap),
		.pc6          (pc6)
	);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// level flags implied by an expected cause, sources above it in priority are idle
	function automatic logic levels_match(input logic [31:0] cause,
		input exe_pkg::trap_s t);
		logic ok;
		if (!cause[31])
		begin
			ok = !t.m_int && !t.s_int && !t.u_int;
		end
		else
		begin
			case (cause[30:0])
				31'd11, 31'd7: ok = t.m_int;
				31'd9:         ok = t.s_int;
				31'd5:         ok = t.s_int && !t.m_int;
				default:       ok = t.u_int && !t.m_int && !t.s_int;
			endcase
		end
		return ok;
	endfunction

	task automatic load_vectors();
		int          fd;
		int          count;
		int          line_no;
		string       text;
		exe_pkg::issue_s ins;
		expect_s     e;
		logic [31:0] ctrl, op_a, op_b, imm, pc, rd, rs1;
		logic [31:0] caddr, cdata, exc, irq_v, mode, offs;
		logic [31:0] wb_we, wb_data, cwb_we, cwb_data, taken, target, t_exc, cause;
		line_no = 0;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0)
			fail_run({"could not open the vector file ", VEC_FILE});
		while ($fgets(text, fd) != 0)
		begin
			line_no++;
			if (text.len() < 2 || text[0] == "#")
				continue;
			count = $sscanf(text,
				"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				ctrl, op_a, op_b, imm, pc, rd, rs1, caddr, cdata, exc, irq_v, mode,
				offs, wb_we, wb_data, cwb_we, cwb_data, taken, target, t_exc, cause);
			if (count != 21)
				fail_run($sformatf("vector line %0d has %0d fields instead of 21",
					line_no, count));
			// ctrl nibbles from the top: alu br jal jalr we wsel cop cuse
			ins             = '0;
			ins.alu_op      = exe_pkg::alu_op_e'(ctrl[31:28]);
			ins.br_cond     = exe_pkg::br_cond_e'(ctrl[26:24]);
			ins.jal         = ctrl[20];
			ins.jalr        = ctrl[16];
			ins.we          = ctrl[12];
			ins.wb_sel      = exe_pkg::wb_sel_e'(ctrl[10:8]);
			ins.csr_op      = exe_pkg::csr_op_e'(ctrl[5:4]);
			ins.csr_use_imm = ctrl[0];
			ins.op_a        = op_a;
			ins.op_b        = op_b;
			// immediates the format does not use carry the inverse of the column
			ins.b_imm       = (ins.br_cond != exe_pkg::BR_NONE) ? imm : ~imm;
			ins.j_imm       = ins.jal ? imm : ~imm;
			ins.u_imm       = (ins.wb_sel == exe_pkg::WB_UIMM ||
				ins.wb_sel == exe_pkg::WB_AUIPC) ? imm : ~imm;
			ins.pc          = pc;
			ins.rd          = rd[4:0];
			ins.rs1         = rs1[4:0];
			// zimm sits in the rs1 field
			ins.csr_imm     = rs1[4:0];
			ins.csr_addr    = caddr[11:0];
			ins.csr_data    = cdata;
			ins.exc         = exe_pkg::exc_flags_s'(exc[5:0]);
			e.wb_off   = offs[11:8];
			e.red_off  = offs[7:4];
			e.trap_off = offs[3:0];
			e.wb_we    = wb_we[0];
			e.wb_data  = wb_data;
			e.cwb_we   = cwb_we[0];
			e.cwb_data = cwb_data;
			e.taken    = taken[0];
			e.target   = target;
			e.exc      = t_exc[0];
			e.cause    = cause;
			vec_issue.push_back(ins);
			vec_irq.push_back(exe_pkg::irq_s'(irq_v[9:0]));
			vec_mode.push_back(exe_pkg::priv_e'(mode[1:0]));
			vec_exp.push_back(e);
			vec_src.push_back(line_no);
		end
		$fclose(fd);
		n_lines = vec_issue.size();
		if (n_lines == 0)
			fail_run("the vector file holds no vectors");
	endtask

	task automatic apply_line(input int j);
		issue        = vec_issue[j];
		irq          = vec_irq[j];
		current_mode = vec_mode[j];
	endtask

	// compare the groups of line j that are due off edges after issue
	task automatic check_line(input int j, input int off);
		expect_s         e;
		exe_pkg::issue_s ins;
		int              src;
		e   = vec_exp[j];
		ins = vec_issue[j];
		src = vec_src[j];
		if (e.wb_off == off)
		begin
			assert (wb.we == e.wb_we)
			else fail_run($sformatf("mismatch at %0t: line %0d wb.we %b, expected %b",
				$time, src, wb.we, e.wb_we));
			if (e.wb_we)
				assert (wb.data == e.wb_data && wb.rd == ins.rd)
				else fail_run($sformatf("mismatch at %0t: line %0d wb x%0d=%h, expected x%0d=%h",
					$time, src, wb.rd, wb.data, ins.rd, e.wb_data));
			assert (csr_wb.we == e.cwb_we)
			else fail_run($sformatf("mismatch at %0t: line %0d csr_wb.we %b, expected %b",
				$time, src, csr_wb.we, e.cwb_we));
			if (e.cwb_we)
				assert (csr_wb.data == e.cwb_data && csr_wb.addr == ins.csr_addr)
				else fail_run($sformatf("mismatch at %0t: line %0d csr %h=%h, expected %h=%h",
					$time, src, csr_wb.addr, csr_wb.data, ins.csr_addr, e.cwb_data));
		end
		// the target only matters when the redirect is taken
		if (e.red_off == off)
			assert (redirect.taken == e.taken && (!e.taken || redirect.target == e.target))
			else fail_run($sformatf("mismatch at %0t: line %0d redirect %b/%h, expected %b/%h",
				$time, src, redirect.taken, redirect.target, e.taken, e.target));
		if (e.trap_off == off)
		begin
			assert (trap.exception == e.exc && trap.cause == e.cause)
			else fail_run($sformatf("mismatch at %0t: line %0d trap %b/%h, expected %b/%h",
				$time, src, trap.exception, trap.cause, e.exc, e.cause));
			assert (levels_match(e.cause, trap))
			else fail_run($sformatf("mismatch at %0t: line %0d levels m%b s%b u%b, cause %h",
				$time, src, trap.m_int, trap.s_int, trap.u_int, e.cause));
			// stage 6 holds this instruction's return code and pc
			if (off == 2)
				assert (trap.ret == ins.exc.ret && (!e.exc || pc6 == ins.pc))
				else fail_run($sformatf("mismatch at %0t: line %0d ret %0d pc6 %h, expected %0d %h",
					$time, src, trap.ret, pc6, ins.exc.ret, ins.pc));
		end
	endtask

	initial
	begin
		nrst         = 1'b0;
		issue        = '0;
		irq          = '0;
		current_mode = exe_pkg::PRIV_M;
		loaded       = 1'b0;
		load_vectors();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		#(PERIOD / 4);
		assert (!wb.we && !csr_wb.we && !redirect.taken && !trap.exception)
		else fail_run($sformatf("mismatch at %0t: outputs active right after reset", $time));
		for (int k = 0; k < n_lines + DRAIN; k++)
		begin
			@(negedge clk);
			if (k < n_lines)
			begin
				apply_line(k);
			end
			else
			begin
				issue = '0;
				irq   = '0;
			end
			// sample halfway between the falling and the rising edge
			#(PERIOD / 4);
			for (int j = k - 2; j <= k; j++)
			begin
				if (j >= 0 && j < n_lines)
					check_line(j, k - j);
			end
		end
		$display("TEST OK");
		$finish;
	end

	initial
	begin
		wait (loaded);
		#((n_lines * 10 + RESET_CYCLES) * PERIOD);
		fail_run("watchdog timeout, the vectors did not finish in time");
	end

endmodule

//--- sources.f
verilog/exe_pkg.sv
verilog/exe_issue_reg.sv
verilog/exe_alu.sv
verilog/csr_update.sv
verilog/trap_ctrl.sv
verilog/exe_commit_reg.sv
verilog/exe_stage.sv
dv/exe_tb.sv

//--- Bender.yml
package:
  name: exe_stage

sources:
  # package first, top level last
  - files:
      - verilog/exe_pkg.sv
      - verilog/exe_issue_reg.sv
      - verilog/exe_alu.sv
      - verilog/csr_update.sv
      - verilog/trap_ctrl.sv
      - verilog/exe_commit_reg.sv
      - verilog/exe_stage.sv

  - target: simulation
    files:
      - dv/exe_tb.sv

//--- dv/exe_vectors.txt
# ctrl(alu br jal jalr we wsel cop cuse) op_a op_b imm pc rd rs1 caddr cdata exc irq mode
# offs(wb red trap, f skips) wb_we wb_data csr_we csr_data taken target exc cause
00001000 5 3 0 100 1 0 0 0 0 0 3 212 1 8 0 0 0 100 0 0
10001000 5 7 0 104 2 0 0 0 0 0 3 212 1 fffffffe 0 0 0 104 0 0
20001000 3 24 0 108 3 0 0 0 0 0 3 212 1 30 0 0 0 108 0 0
30001000 fffffff0 1 0 10c 4 0 0 0 0 0 3 212 1 1 0 0 0 10c 0 0
40001000 fffffff0 1 0 110 5 0 0 0 0 0 3 212 1 0 0 0 0 110 0 0
50001000 0f0f0f0f 00ff00ff 0 114 6 0 0 0 0 0 3 212 1 0ff00ff0 0 0 0 114 0 0
60001000 80000000 4 0 118 7 0 0 0 0 0 3 212 1 08000000 0 0 0 118 0 0
70001000 80000000 4 0 11c 8 0 0 0 0 0 3 212 1 f8000000 0 0 0 11c 0 0
80001000 0f0f0f0f 00ff00ff 0 120 9 0 0 0 0 0 3 212 1 0fff0fff 0 0 0 120 0 0
90001000 0f0f0f0f 00ff00ff 0 124 a 0 0 0 0 0 3 212 1 000f000f 0 0 0 124 0 0
00001000 1 1 0 128 0 0 0 0 0 0 3 212 0 0 0 0 0 128 0 0
01000000 5 5 10 200 0 0 0 0 0 0 3 212 0 0 0 0 1 210 0 0
02000000 5 5 10 204 0 0 0 0 0 0 3 212 0 0 0 0 0 214 0 0
03000000 fffffff0 1 fffffff8 208 0 0 0 0 0 0 3 212 0 0 0 0 1 200 0 0
04000000 fffffff0 1 8 20c 0 0 0 0 0 0 3 212 0 0 0 0 0 214 0 0
05000000 fffffff0 1 8 210 0 0 0 0 0 0 3 212 0 0 0 0 0 218 0 0
06000000 fffffff0 1 20 214 0 0 0 0 0 0 3 212 0 0 0 0 1 234 0 0
00101100 0 0 40 300 1 0 0 0 0 0 3 212 1 304 0 0 1 340 0 0
00011100 1001 4 0 304 2 0 0 0 0 0 3 212 1 308 0 0 1 1004 0 0
00001200 0 0 12345000 308 3 0 0 0 0 0 3 2f2 1 12345000 0 0 0 0 0 0
00001300 0 0 1000 30c 4 0 0 0 0 0 3 2f2 1 130c 0 0 0 0 0 0
00001410 deadbeef 0 0 400 6 5 300 88 0 0 3 2f2 1 88 1 deadbeef 0 0 0 0
00001420 f 0 0 404 7 5 300 f0 0 0 3 2f2 1 f0 1 ff 0 0 0 0
00001430 11 0 0 408 8 5 300 ff 0 0 3 2f2 1 ff 1 ee 0 0 0 0
00001411 ffffffff 0 0 40c 9 1f 300 0 0 0 3 2f2 1 0 1 1f 0 0 0 0
00001421 0 0 0 410 a 3 300 80 0 0 3 2f2 1 80 1 83 0 0 0 0
00001431 0 0 0 414 b 1 300 83 0 0 3 2f2 1 83 1 82 0 0 0 0
00001420 55 0 0 418 c 0 300 44 0 0 3 2f2 1 44 0 0 0 0 0 0
00000000 0 0 0 500 0 0 0 0 10 0 3 2f2 0 0 0 0 0 0 1 b
00001000 1 2 0 504 d 0 0 0 0 0 3 2f2 0 0 0 0 0 0 0 0
00001000 1 2 0 508 e 0 0 0 0 0 3 2f2 0 0 0 0 0 0 0 0
00000000 0 0 0 50c 0 0 0 0 10 0 0 2f2 0 0 0 0 0 0 1 8
00000000 0 0 0 0 0 0 0 0 0 0 0 fff 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0 0 0 0 fff 0 0 0 0 0 0 0 0
00000000 0 0 0 510 0 0 0 0 10 0 1 2f2 0 0 0 0 0 0 1 9
00000000 0 0 0 0 0 0 0 0 0 0 1 fff 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0 0 0 1 fff 0 0 0 0 0 0 0 0
00000410 1 0 0 514 0 5 c00 7 0 0 3 2f2 0 0 0 0 0 0 1 2
00000000 0 0 0 0 0 0 0 0 0 0 3 fff 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0 0 0 3 fff 0 0 0 0 0 0 0 0
00000420 0 0 0 518 0 0 300 0 0 0 0 2f2 0 0 0 0 0 0 1 2
00000000 0 0 0 0 0 0 0 0 0 0 0 fff 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0 0 0 0 fff 0 0 0 0 0 0 0 0
00000000 0 0 0 51c 0 0 0 0 8 0 3 2f2 0 0 0 0 0 0 1 3
00000000 0 0 0 0 0 0 0 0 0 0 3 fff 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0 0 0 3 fff 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0 0 200 3 ff0 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0 0 220 3 ff0 0 0 0 0 0 0 1 80000007
00000000 0 0 0 0 0 0 0 0 0 110 3 ff0 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0 0 110 1 ff0 0 0 0 0 0 0 1 80000005
00000000 0 0 0 0 0 0 0 0 0 088 1 ff0 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0 0 088 0 ff0 0 0 0 0 0 0 1 80000004
00000000 0 0 0 0 0 0 0 0 0 041 0 ff0 0 0 0 0 0 0 1 80000008
00000000 0 0 0 0 0 0 0 0 0 3ff 0 ff0 0 0 0 0 0 0 1 8000000b
00000000 0 0 0 0 0 0 0 0 0 263 0 ff0 0 0 0 0 0 0 1 80000009
00000000 0 0 0 0 0 0 0 0 0 371 1 ff0 0 0 0 0 0 0 1 80000007
00000000 0 0 0 0 0 0 0 0 0 151 0 ff0 0 0 0 0 0 0 1 80000005
00000000 0 0 0 0 0 0 0 0 0 0c9 0 ff0 0 0 0 0 0 0 1 80000008
00000000 0 0 0 0 0 0 0 0 0 000 3 ff0 0 0 0 0 0 0 0 0
